// File: bundle_fetch.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module bundle_fetch (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         bundle_req,
	input  logic [`QSLOTS*`INSN_W-1:0]   bundle_data,
	input  logic [`QSLOTS-1:0]           bundle_mask,
	input  logic [`QSLOTS-1:0]           slotv,
	output logic                         bundle_ack,
	output logic                         nextb,
	output logic [`QSLOTS*`INSN_W-1:0]   bundle_insn,
	output logic [`QSLOTS-1:0]           ip_mask
);

	fetch_pkg::hs_state_e state;

	// take a new bundle only once every slot of the old one has drained
	// a pending request simply waits here, which is the back-pressure
	assign nextb = (state == fetch_pkg::hs_idle) && bundle_req && (slotv == '0);

	// producer side handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fetch_pkg::hs_idle;
			bundle_ack <= 1'b0;
		end else begin
			case (state)
				fetch_pkg::hs_idle: begin
					if (nextb) begin
						bundle_ack <= 1'b1;
						state <= fetch_pkg::hs_wait_drop;
					end
				end
				fetch_pkg::hs_wait_drop: begin
					// hold ack until producer lets go of req
					if (!bundle_req) begin
						bundle_ack <= 1'b0;
						state <= fetch_pkg::hs_idle;
					end
				end
				default: state <= fetch_pkg::hs_idle;
			endcase
		end
	end

	// bundle register, loaded in the accept cycle
	always_ff @(posedge clk) begin
		if (nextb) begin
			bundle_insn <= bundle_data;
			ip_mask <= bundle_mask;
		end
	end

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

`include "frontend_consts.svh"

	// ======================================================================
	// handshake and micro-op types
	// ======================================================================

	// four-phase handshake phases
	// idle: waiting for the request (or for something to send)
	// wait_drop: ack/req is up, waiting for the other side to drop
	typedef enum logic {
		hs_idle,
		hs_wait_drop
	} hs_state_e;

	// which micro-op of an lsm an issue queue entry holds
	// plain instructions always travel as the first half
	typedef enum logic [$clog2(`LSM_UOPS)-1:0] {
		half_first,
		half_second
	} uop_half_e;

endpackage

// File: frontend_assertions.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frontend_assertions (
	input logic               clk,
	input logic               rst,
	input logic               bundle_req,
	input logic               bundle_ack,
	input logic [`QSLOTS-1:0] slotv,
	input logic               out_req,
	input logic               out_ack
);

	// a bundle has been accepted since reset
	logic bundle_seen;

	always_ff @(posedge clk) begin
		if (rst)
			bundle_seen <= 1'b0;
		else if (bundle_ack)
			bundle_seen <= 1'b1;
	end

	// ======================================================================
	// four-phase request rules
	// ======================================================================

	// producer keeps its request up until the front end answers
	bundle_req_held: assert property (@(posedge clk) disable iff (rst)
		bundle_req && !bundle_ack |=> bundle_req)
		else $error("bundle_req dropped before bundle_ack");

	// consumer keeps its ack up until the front end drops the request
	out_ack_held: assert property (@(posedge clk) disable iff (rst)
		out_ack && out_req |=> out_ack)
		else $error("out_ack dropped before out_req fell");

	// ======================================================================
	// slot and reset rules
	// ======================================================================

	// a bundle is taken only after the previous one has fully drained
	ack_on_empty: assert property (@(posedge clk) disable iff (rst)
		$rose(bundle_ack) |-> ($past(slotv) == '0))
		else $error("bundle_ack raised while slots were still valid");

	// reset leaves the output side quiet until a bundle comes in
	quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		$rose(out_req) |-> bundle_seen)
		else $error("out_req raised before any bundle was accepted");

endmodule

// attached to every front end top level
bind frontend_top frontend_assertions u_assertions (
	.clk        (clk),
	.rst        (rst),
	.bundle_req (bundle_req),
	.bundle_ack (bundle_ack),
	.slotv      (slotv),
	.out_req    (out_req),
	.out_ack    (out_ack)
);

// File: frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// ======================================================================
// front end sizing
// ======================================================================

// instruction slots per fetched bundle
`define QSLOTS 3

// width of one instruction word
`define INSN_W 16

// issue queue entries
`define QDEPTH 8

// micro-ops produced by one load/store-multiple
`define LSM_UOPS 2

`endif

// File: frontend_golden.txt
# T <test> <predict_en> <slow consumer> <flush first>
# B <mask> <data slot2 slot1 slot0> <word count> then <insn> <half> per expected word
T 1 1 0 0
B 7 210310220011 3 0011 0 1022 0 2103 0
B 5 0206ffff0105 2 0105 0 0206 0
B 2 aaaa1107bbbb 1 1107 0
B 3 0000230a010b 2 010b 0 230a 0
T 2 1 0 0
B 7 020c3a0d010e 4 010e 0 3a0d 0 3a0d 1 020c 0
B 1 000000003b0f 2 3b0f 0 3b0f 1
B 6 3c10021100ff 3 0211 0 3c10 0 3c10 1
T 3 1 0 0
B 7 02124a130114 2 0114 0 4a13 0
B 7 031503160317 0
B 7 5d2221191120 3 1120 0 2119 0 5d22 0
B 7 012801290130 0
B 5 0226ffff6027 1 6027 0
B 3 000011240125 0
B 7 0231032d782a 1 782a 0
B 7 032c032d032e 0
B 7 702f1130203a 3 203a 0 1130 0 702f 0
B 1 00000000013b 1 013b 0
T 4 0 0 0
B 7 03314a320133 3 0133 0 4a32 0 0331 0
B 7 023478356036 3 6036 0 7835 0 0234 0
B 3 000011375d38 2 5d38 0 1137 0
T 5 0 1 0
B 7 024101420143 3 0143 0 0142 0 0241 0
B 7 324411450146 4 0146 0 1145 0 3244 0 3244 1
B 7 024702480249 3 0249 0 0248 0 0247 0
B 7 124a114b014c 3 014c 0 114b 0 124a 0
T 6 1 0 1
B 7 015201510150 3 0150 0 0151 0 0152 0
B 4 335300000000 2 3353 0 3353 1

// File: frontend_top.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module frontend_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  logic                       predict_en,
	// bundle producer
	input  logic                       bundle_req,
	input  logic [`QSLOTS*`INSN_W-1:0] bundle_data,
	input  logic [`QSLOTS-1:0]         bundle_mask,
	output logic                       bundle_ack,
	// instruction consumer
	output logic                       out_req,
	output logic [`INSN_W-1:0]         out_insn,
	output logic                       out_half,
	input  logic                       out_ack
);

	// bundle register and its slot mask
	logic [`QSLOTS*`INSN_W-1:0] bundle_insn;
	logic [`QSLOTS-1:0]         ip_mask;
	logic                       nextb;
	// predecode flags per slot
	logic [`QSLOTS-1:0]         slot_lsm;
	logic [`QSLOTS-1:0]         slot_jc;
	logic [`QSLOTS-1:0]         slot_ret;
	logic [`QSLOTS-1:0]         take_branch;
	// queuing feedback
	logic [`QSLOTS-1:0]         slotv;
	logic [1:0]                 queued_cnt;
	logic [`QSLOTS-1:0]         lsm_pending;

	bundle_fetch u_fetch (
		.clk         (clk),
		.rst         (rst),
		.bundle_req  (bundle_req),
		.bundle_data (bundle_data),
		.bundle_mask (bundle_mask),
		.slotv       (slotv),
		.bundle_ack  (bundle_ack),
		.nextb       (nextb),
		.bundle_insn (bundle_insn),
		.ip_mask     (ip_mask)
	);

	slot_predecode u_predecode (
		.bundle_insn (bundle_insn),
		.predict_en  (predict_en),
		.slot_lsm    (slot_lsm),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch)
	);

	slot_valid u_valid (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.nextb       (nextb),
		.ip_mask     (ip_mask),
		.queued_cnt  (queued_cnt),
		.lsm_pending (lsm_pending),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch),
		.predict_en  (predict_en),
		.slotv       (slotv)
	);

	issue_queue u_queue (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.slotv       (slotv),
		.bundle_insn (bundle_insn),
		.slot_lsm    (slot_lsm),
		.slot_jc     (slot_jc),
		.slot_ret    (slot_ret),
		.take_branch (take_branch),
		.queued_cnt  (queued_cnt),
		.lsm_pending (lsm_pending),
		.out_req     (out_req),
		.out_insn    (out_insn),
		.out_half    (out_half),
		.out_ack     (out_ack)
	);

endmodule

// File: isa_pkg.sv
package isa_pkg;

	// ======================================================================
	// instruction format
	// ======================================================================

	// opcode sits in the top nibble of each 16-bit instruction
	localparam int OPC_LSB = 12;
	localparam int OPC_W = 4;

	// static prediction hint of a conditional branch
	localparam int BR_PRED_BIT = 11;

	typedef enum logic [OPC_W-1:0] {
		op_alu   = 4'h0,
		op_load  = 4'h1,
		op_store = 4'h2,
		// load/store-multiple, issued as two micro-ops
		op_lsm   = 4'h3,
		op_jmp   = 4'h4,
		op_call  = 4'h5,
		op_ret   = 4'h6,
		// conditional branch, taken when bit 11 set
		op_br    = 4'h7
	} opcode_e;

	// predecode result for one slot
	typedef struct packed {
		logic lsm;
		// jump or call
		logic jc;
		logic ret;
		// branch predicted taken, already qualified by predict enable
		logic taken;
	} slot_kind_t;

endpackage

// File: issue_queue.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module issue_queue (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       flush,
	input  logic [`QSLOTS-1:0]         slotv,
	input  logic [`QSLOTS*`INSN_W-1:0] bundle_insn,
	input  logic [`QSLOTS-1:0]         slot_lsm,
	input  logic [`QSLOTS-1:0]         slot_jc,
	input  logic [`QSLOTS-1:0]         slot_ret,
	input  logic [`QSLOTS-1:0]         take_branch,
	output logic [1:0]                 queued_cnt,
	output logic [`QSLOTS-1:0]         lsm_pending,
	output logic                       out_req,
	output logic [`INSN_W-1:0]         out_insn,
	output logic                       out_half,
	input  logic                       out_ack
);

	localparam int PTR_W = $clog2(`QDEPTH);

	// circular FIFO storage
	logic [`INSN_W-1:0]   insn_mem [`QDEPTH];
	fetch_pkg::uop_half_e half_mem [`QDEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	// occupancy, one bit wider than the pointers
	logic [PTR_W:0]       count;
	logic [PTR_W:0]       free_cnt;
	// first half of this slot's lsm already queued
	logic [`QSLOTS-1:0]   half_q;
	// slots queued this cycle
	logic [`QSLOTS-1:0]   take;
	// micro-ops packed in write order
	logic [`INSN_W-1:0]   wr_insn [`QSLOTS];
	fetch_pkg::uop_half_e wr_half [`QSLOTS];
	fetch_pkg::hs_state_e out_state;
	logic                 deq;

	assign free_cnt = (PTR_W+1)'(`QDEPTH) - count;
	assign lsm_pending = slot_lsm & ~half_q & slotv;

	// ======================================================================
	// select slots to queue
	// ======================================================================
	always_comb begin
		logic [PTR_W:0] n;
		logic stop;
		n = '0;
		stop = 1'b0;
		take = '0;
		for (int j = 0; j < `QSLOTS; j++) begin
			wr_insn[j] = '0;
			wr_half[j] = fetch_pkg::half_first;
		end
		for (int i = 0; i < `QSLOTS; i++) begin
			if (slotv[i] && !stop) begin
				if (n < free_cnt) begin
					take[i] = 1'b1;
					wr_insn[n[1:0]] = bundle_insn[i*`INSN_W +: `INSN_W];
					wr_half[n[1:0]] = half_q[i] ? fetch_pkg::half_second
						: fetch_pkg::half_first;
					n = n + 1'b1;
					// control transfer ends the group, slot_valid decides on a stomp
					if (slot_jc[i] || slot_ret[i] || take_branch[i])
						stop = 1'b1;
					// second half of an lsm waits for next cycle
					if (lsm_pending[i])
						stop = 1'b1;
				end else begin
					// queue full, keep slot order
					stop = 1'b1;
				end
			end
		end
		queued_cnt = n[1:0];
	end

	// one entry leaves per completed output handshake
	assign deq = (out_state == fetch_pkg::hs_wait_drop) && out_req && out_ack
		&& (count != '0);

	// pointers, occupancy and lsm half tracking
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			half_q <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(queued_cnt);
			rd_ptr <= rd_ptr + PTR_W'(deq);
			count <= count + (PTR_W+1)'(queued_cnt) - (PTR_W+1)'(deq);
			// lsm toggles first -> second -> done
			for (int i = 0; i < `QSLOTS; i++) begin
				if (take[i] && slot_lsm[i])
					half_q[i] <= ~half_q[i];
			end
		end
	end

	// FIFO writes, up to three per cycle
	always_ff @(posedge clk) begin
		for (int j = 0; j < `QSLOTS; j++) begin
			if (j < int'(queued_cnt)) begin
				insn_mem[wr_ptr + PTR_W'(j)] <= wr_insn[j];
				half_mem[wr_ptr + PTR_W'(j)] <= wr_half[j];
			end
		end
	end

	// ======================================================================
	// output four-phase handshake
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			out_state <= fetch_pkg::hs_idle;
			out_req <= 1'b0;
		end else begin
			case (out_state)
				fetch_pkg::hs_idle: begin
					// consumer must have dropped ack from the last word
					if ((count != '0) && !out_ack && !flush) begin
						out_req <= 1'b1;
						out_state <= fetch_pkg::hs_wait_drop;
					end
				end
				fetch_pkg::hs_wait_drop: begin
					if (out_req && out_ack)
						out_req <= 1'b0;
					else if (!out_req && !out_ack)
						out_state <= fetch_pkg::hs_idle;
				end
				default: out_state <= fetch_pkg::hs_idle;
			endcase
		end
	end

	// head entry is latched while idle and held through the handshake
	always_ff @(posedge clk) begin
		if (out_state == fetch_pkg::hs_idle) begin
			out_insn <= insn_mem[rd_ptr];
			out_half <= half_mem[rd_ptr];
		end
	end

endmodule

// File: project.f
+incdir+.
isa_pkg.sv
fetch_pkg.sv
bundle_fetch.sv
slot_predecode.sv
slot_valid.sv
issue_queue.sv
frontend_top.sv
frontend_assertions.sv
tb_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_frontend -f project.f \
	-o tb_frontend > build.log 2>&1 \
	&& ./obj_dir/tb_frontend > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: slot_predecode.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module slot_predecode (
	input  logic [`QSLOTS*`INSN_W-1:0] bundle_insn,
	input  logic                       predict_en,
	output logic [`QSLOTS-1:0]         slot_lsm,
	output logic [`QSLOTS-1:0]         slot_jc,
	output logic [`QSLOTS-1:0]         slot_ret,
	output logic [`QSLOTS-1:0]         take_branch
);

	// classify one instruction word
	function automatic isa_pkg::slot_kind_t decode_slot(
		input logic [`INSN_W-1:0] insn,
		input logic               pen
	);
		isa_pkg::opcode_e op;
		isa_pkg::slot_kind_t k;
		op = isa_pkg::opcode_e'(insn[isa_pkg::OPC_LSB +: isa_pkg::OPC_W]);
		k = '0;
		case (op)
			isa_pkg::op_lsm: k.lsm = 1'b1;
			// call and jmp share one flag, both end the group
			isa_pkg::op_jmp,
			isa_pkg::op_call: k.jc = 1'b1;
			isa_pkg::op_ret: k.ret = 1'b1;
			// hint bit counts only with prediction on
			isa_pkg::op_br: k.taken = insn[isa_pkg::BR_PRED_BIT] & pen;
			default: k = '0;
		endcase
		return k;
	endfunction

	always_comb begin
		isa_pkg::slot_kind_t kind;
		// slot i lives in bits [16*i +: 16]
		for (int i = 0; i < `QSLOTS; i++) begin
			kind = decode_slot(bundle_insn[i*`INSN_W +: `INSN_W], predict_en);
			slot_lsm[i] = kind.lsm;
			slot_jc[i] = kind.jc;
			slot_ret[i] = kind.ret;
			take_branch[i] = kind.taken;
		end
	end

endmodule

// File: slot_valid.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module slot_valid (
	input  logic               clk,
	input  logic               rst,
	input  logic               flush,
	input  logic               nextb,
	input  logic [`QSLOTS-1:0] ip_mask,
	input  logic [1:0]         queued_cnt,
	input  logic [`QSLOTS-1:0] lsm_pending,
	input  logic [`QSLOTS-1:0] slot_jc,
	input  logic [`QSLOTS-1:0] slot_ret,
	input  logic [`QSLOTS-1:0] take_branch,
	input  logic               predict_en,
	output logic [`QSLOTS-1:0] slotv
);

	// delayed valid register, the slots still to be queued
	logic [`QSLOTS-1:0] slotvd;
	// valids left after this cycle's queuing
	logic [`QSLOTS-1:0] slotv_nxt;
	// a control transfer was queued this cycle
	logic stomp_set;
	// stomp on next bundle
	logic stomp_next;
	// bundle register and ip_mask hold the new bundle, one edge after nextb
	logic load_d;
	// slots that redirect fetch when queued
	logic [`QSLOTS-1:0] ctl;

	assign ctl = (slot_jc | slot_ret | take_branch) & {`QSLOTS{predict_en}};

	// slots offered to the issue queue this cycle
	assign slotv = slotvd;

	// ======================================================================
	// retire queued slots in order
	// ======================================================================
	always_comb begin
		logic [1:0] seen;
		seen = 2'd0;
		slotv_nxt = slotvd;
		stomp_set = 1'b0;
		// lowest valid slots go first, queued_cnt of them
		for (int i = 0; i < `QSLOTS; i++) begin
			if (slotvd[i] && (seen < queued_cnt)) begin
				seen = seen + 2'd1;
				// lsm with only its first half out stays valid
				if (!lsm_pending[i])
					slotv_nxt[i] = 1'b0;
				if (ctl[i])
					stomp_set = 1'b1;
			end
		end
		// fetch is redirected, rest of the bundle is dead
		if (stomp_set)
			slotv_nxt = '0;
	end

	// ======================================================================
	// valid register and stomp flag
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst || flush)
			load_d <= 1'b0;
		else
			load_d <= nextb;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slotvd <= '0;
			stomp_next <= 1'b0;
		end else if (flush) begin
			// flush wins over a bundle arriving the same cycle
			slotvd <= '0;
			stomp_next <= 1'b0;
		end else if (load_d) begin
			// the bundle right after a redirect never becomes valid
			slotvd <= stomp_next ? '0 : ip_mask;
			stomp_next <= 1'b0;
		end else begin
			slotvd <= slotv_nxt;
			if (stomp_set)
				stomp_next <= 1'b1;
		end
	end

endmodule

// File: tb_frontend.sv
`timescale 1ns/1ps
`include "frontend_consts.svh"

module tb_frontend;

	localparam int MAX_TESTS = 16;
	// jmp opcode in the top nibble, nothing else set
	localparam logic [`INSN_W-1:0] JMP_WORD = 16'h4000;

	logic                       clk;
	logic                       rst;
	logic                       flush;
	logic                       predict_en;
	logic                       bundle_req;
	logic [`QSLOTS*`INSN_W-1:0] bundle_data;
	logic [`QSLOTS-1:0]         bundle_mask;
	logic                       bundle_ack;
	logic                       out_req;
	logic [`INSN_W-1:0]         out_insn;
	logic                       out_half;
	logic                       out_ack;

	// per test settings, bundle and word counts
	int n_tests;
	int t_pen [MAX_TESTS];
	int t_slow [MAX_TESTS];
	int t_flush [MAX_TESTS];
	int t_nb [MAX_TESTS];
	int t_nw [MAX_TESTS];
	// all bundles and expected words, in file order
	logic [`QSLOTS-1:0]         gb_mask [$];
	logic [`QSLOTS*`INSN_W-1:0] gb_data [$];
	logic [`INSN_W-1:0]         gw_insn [$];
	logic                       gw_half [$];

	int errors;
	int checks;
	int seed;
	bit loaded;

	frontend_top uut (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush),
		.predict_en  (predict_en),
		.bundle_req  (bundle_req),
		.bundle_data (bundle_data),
		.bundle_mask (bundle_mask),
		.bundle_ack  (bundle_ack),
		.out_req     (out_req),
		.out_insn    (out_insn),
		.out_half    (out_half),
		.out_ack     (out_ack)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// golden file reader
	// ======================================================================
	task automatic read_golden();
		int fd;
		int r;
		int n;
		int h;
		int id;
		logic [63:0] tok;
		logic [1023:0] rest;
		logic [`QSLOTS-1:0] m;
		logic [`QSLOTS*`INSN_W-1:0] d;
		logic [`INSN_W-1:0] w;
		n_tests = 0;
		fd = $fopen("frontend_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open frontend_golden.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			if (tok == 64'("#")) begin
				// column notes, rest of the line is text
				r = $fgets(rest, fd);
			end else if (tok == 64'("T") && n_tests < MAX_TESTS) begin
				r = $fscanf(fd, "%d %d %d %d", id, t_pen[n_tests], t_slow[n_tests],
					t_flush[n_tests]);
				t_nb[n_tests] = 0;
				t_nw[n_tests] = 0;
				n_tests++;
			end else if (tok == 64'("B") && n_tests > 0) begin
				r = $fscanf(fd, "%h %h %d", m, d, n);
				gb_mask.push_back(m);
				gb_data.push_back(d);
				t_nb[n_tests-1]++;
				t_nw[n_tests-1] += n;
				// expected words of this bundle follow on the same line
				for (int k = 0; k < n; k++) begin
					r = $fscanf(fd, "%h %d", w, h);
					gw_insn.push_back(w);
					gw_half.push_back(h[0]);
				end
			end
		end
		$fclose(fd);
	endtask

	// ======================================================================
	// producer and consumer
	// ======================================================================
	task automatic send_one(input logic [`QSLOTS*`INSN_W-1:0] data,
		input logic [`QSLOTS-1:0] mask);
		@(posedge clk);
		bundle_req <= 1'b1;
		bundle_data <= data;
		bundle_mask <= mask;
		do @(negedge clk); while (!bundle_ack);
		@(posedge clk);
		bundle_req <= 1'b0;
		// next request only once ack is down again
		do @(negedge clk); while (bundle_ack);
	endtask

	task automatic send_bundles(input int first, input int n);
		for (int i = first; i < first + n; i++)
			send_one(gb_data[i], gb_mask[i]);
	endtask

	task automatic take_one(input logic [`INSN_W-1:0] exp_insn, input logic exp_half,
		input bit slow);
		int gap;
		do @(negedge clk); while (!out_req);
		checks += 2;
		assert (out_insn == exp_insn) else begin
			$display("Mismatch at %0t ns: out_insn expected %h got %h",
				$time, exp_insn, out_insn);
			errors++;
		end
		assert (out_half == exp_half) else begin
			$display("Mismatch at %0t ns: out_half expected %0d got %0d",
				$time, exp_half, out_half);
			errors++;
		end
		// slow consumer stretches the ack so the queue backs up
		gap = slow ? ($random(seed) & 7) : ($random(seed) & 1);
		repeat (gap) @(posedge clk);
		@(posedge clk);
		out_ack <= 1'b1;
		do @(negedge clk); while (out_req);
		@(posedge clk);
		out_ack <= 1'b0;
	endtask

	task automatic take_words(input int first, input int n, input bit slow);
		for (int i = first; i < first + n; i++)
			take_one(gw_insn[i], gw_half[i], slow);
	endtask

	// one jmp with prediction on, the bundle after it is due for a stomp
	task automatic prime_stomp();
		predict_en <= 1'b1;
		fork
			send_one({32'h0, JMP_WORD}, 3'b001);
			take_one(JMP_WORD, 1'b0, 1'b0);
		join
	endtask

	task automatic run_test(input int t, input int b0, input int w0);
		int err0;
		int extra;
		err0 = errors;
		extra = 0;
		@(posedge clk);
		if (t_flush[t] != 0) begin
			// a pending stomp gives the flush something to clear
			prime_stomp();
			@(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
		end
		predict_en <= t_pen[t][0];
		fork
			send_bundles(b0, t_nb[t]);
			take_words(w0, t_nw[t], t_slow[t] != 0);
		join
		// stream is complete, any further request is a stray word
		repeat (12) begin
			@(negedge clk);
			if (out_req)
				extra = 1;
		end
		checks++;
		assert (extra == 0) else begin
			$display("test %0d: front end offered a word beyond the expected stream", t + 1);
			errors++;
		end
		$display("test %0d %s: %0d bundles, %0d words", t + 1,
			(errors == err0) ? "passed" : "failed", t_nb[t], t_nw[t]);
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		int b0;
		int w0;
		seed = 32'h709c;
		errors = 0;
		checks = 0;
		rst = 1'b1;
		flush = 1'b0;
		predict_en = 1'b0;
		bundle_req = 1'b0;
		bundle_data = '0;
		bundle_mask = '0;
		out_ack = 1'b0;
		read_golden();
		loaded = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		b0 = 0;
		w0 = 0;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t, b0, w0);
			b0 += t_nb[t];
			w0 += t_nw[t];
		end
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0 && n_tests > 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog, 40 cycles per bundle with flush primers counted,
	// plus reset and per test settling
	initial begin
		int budget;
		int primes;
		wait (loaded);
		primes = 0;
		for (int t = 0; t < n_tests; t++) begin
			if (t_flush[t] != 0)
				primes++;
		end
		budget = 40 * (gb_data.size() + primes) + 20 * n_tests + 40;
		repeat (budget) @(posedge clk);
		$display("timeout after %0d cycles, the front end stopped moving", budget);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
